//--- vlog.f
cache_pkg.sv
cache_controller.sv
cache_datapath.sv
mem_port.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

//--- run.sh
#!/bin/sh
# compile and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f vlog.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "NO ERRORS"; then
	exit 0
fi
exit 1

//--- tb_cache.sv
`timescale 1ns/1ps

module tb_cache;
	import cache_pkg::*;

	localparam int NUM_LINES   = 16;
	localparam int MEM_CREDITS = 2;
	localparam int SEED        = 32'h303b;
	localparam int NUM_RAND    = 60;
	localparam int NUM_DIRTY   = 24;
	localparam int NUM_OPS     = NUM_RAND + 2 * NUM_DIRTY + 10;

	logic              clk = 1'b0;
	logic              n_rst;
	logic              cpu_req;
	cpu_req_t          cpu_cmd;
	logic              cpu_flush;
	cpu_rsp_t          cpu_rsp;
	logic              cache_ready;
	logic              flush_done;
	mem_req_t          mem_req;
	mem_rsp_t          mem_rsp;
	logic              mem_credit;
	logic              hold_credit;
	integer            seed = SEED;
	logic [DATA_W-1:0] shadow [2**ADDR_W];
	logic [DATA_W-1:0] exp_rdata;
	logic              expect_hit;
	logic              starved;
	logic              started;
	int                outstanding;
	mem_req_t          req_log [$];

	always #50 clk = ~clk;

	cache_top #(
		.NUM_LINES   (NUM_LINES),
		.MEM_CREDITS (MEM_CREDITS)
	) DUT (.*);

	tb_mem_model #(
		.SEED (SEED)
	) mem_model (.*);

	task automatic stop_on_error();
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
		stop_on_error();
	endtask

	task automatic text_error(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		stop_on_error();
	endtask

	// pattern covers all 16 address bits
	function automatic logic [DATA_W-1:0] fill_word(input int addr);
		return {addr[15:0] ^ 16'h5a5a, ~addr[15:0]};
	endfunction

	always @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(mem_req.valid) - int'(mem_credit);
			if (mem_req.valid) begin
				req_log.push_back(mem_req);
			end
		end
	end

	assert property (@(posedge clk) disable iff (!n_rst)
		(cpu_rsp.done && !cpu_cmd.rw) |-> (cpu_rsp.rdata == exp_rdata))
	else value_error("cpu_rsp.rdata", cpu_rsp.rdata, exp_rdata);

	assert property (@(posedge clk) disable iff (!n_rst)
		(expect_hit && $past(cpu_req)) |-> cpu_rsp.done)
	else text_error("hit did not finish one cycle after the request");

	assert property (@(posedge clk) disable iff (!n_rst)
		mem_req.valid |-> (outstanding < MEM_CREDITS))
	else text_error("memory request issued with all credits in use");

	assert property (@(posedge clk) disable iff (!n_rst) starved |-> !mem_req.valid)
	else text_error("memory request issued before a credit came back");

	assert property (@(posedge clk) disable iff (!n_rst)
		!started |-> (cache_ready && !mem_req.valid && !cpu_rsp.done && !flush_done))
	else text_error("outputs not idle after reset");

	task automatic cache_op(input logic rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		while (!cache_ready) @(negedge clk);
		started   = 1'b1;
		cpu_cmd   = '{rw: rw, addr: addr, wdata: wdata};
		exp_rdata = shadow[addr];
		cpu_req   = 1'b1;
		@(negedge clk);
		cpu_req = 1'b0;
		while (!cpu_rsp.done) @(negedge clk);
		if (rw) begin
			shadow[addr] = wdata;
		end
		@(negedge clk);
	endtask

	task automatic flush_cache();
		while (!cache_ready) @(negedge clk);
		cpu_flush = 1'b1;
		while (!flush_done) @(negedge clk);
		@(negedge clk);
		cpu_flush = 1'b0;
	endtask

	initial begin
		int                r;
		logic [DATA_W-1:0] d;
		logic [ADDR_W-1:0] addr_a;
		logic [ADDR_W-1:0] addr_b;
		logic [ADDR_W-1:0] written [$];
		n_rst       = 1'b0;
		cpu_req     = 1'b0;
		cpu_cmd     = '0;
		cpu_flush   = 1'b0;
		hold_credit = 1'b0;
		expect_hit  = 1'b0;
		starved     = 1'b0;
		started     = 1'b0;
		exp_rdata   = '0;
		for (int i = 0; i < 2**ADDR_W; i++) begin
			shadow[i]        = fill_word(i);
			mem_model.mem[i] = fill_word(i);
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		n_rst = 1'b1;
		repeat (3) @(negedge clk);

		// mixed reads and writes over 64 words
		repeat (NUM_RAND) begin
			r = $random(seed);
			d = $random(seed);
			cache_op(r[8], {10'd0, r[5:0]}, d);
		end

		addr_a = 16'h0007;
		cache_op(1'b0, addr_a, '0);
		expect_hit = 1'b1;
		cache_op(1'b1, addr_a, 32'hcafe_0007);
		cache_op(1'b0, addr_a, '0);
		expect_hit = 1'b0;

		// other tag on the same index forces the dirty line out first
		addr_b = addr_a ^ 16'h0010;
		req_log.delete();
		cache_op(1'b0, addr_b, '0);
		assert (req_log.size() == 2)
		else text_error("eviction did not give one write and one read");
		assert (req_log[0].write) else text_error("first eviction request is not a write");
		assert (req_log[0].addr == addr_a)
		else value_error("mem_req.addr", 32'(req_log[0].addr), 32'(addr_a));
		assert (req_log[0].wdata == 32'hcafe_0007)
		else value_error("mem_req.wdata", req_log[0].wdata, 32'hcafe_0007);
		assert (!req_log[1].write) else text_error("second eviction request is not a read");
		assert (req_log[1].addr == addr_b)
		else value_error("mem_req.addr", 32'(req_log[1].addr), 32'(addr_b));
		cache_op(1'b0, addr_a, '0);

		repeat (NUM_DIRTY) begin
			r = $random(seed);
			d = $random(seed);
			cache_op(1'b1, {10'd0, r[5:0]}, d);
			written.push_back({10'd0, r[5:0]});
		end
		flush_cache();
		for (int i = 0; i < 2**ADDR_W; i++) begin
			assert (mem_model.mem[i] == shadow[i])
			else value_error($sformatf("mem[0x%04h]", i), mem_model.mem[i], shadow[i]);
		end
		req_log.delete();
		foreach (written[i]) begin
			cache_op(1'b0, written[i], '0);
		end
		foreach (req_log[i]) begin
			assert (!req_log[i].write) else text_error("read after flush wrote to memory");
		end

		// both credits used up and held back
		while (outstanding != 0) @(negedge clk);
		hold_credit = 1'b1;
		cache_op(1'b0, 16'h0100, '0);
		cache_op(1'b0, 16'h0101, '0);
		fork
			cache_op(1'b0, 16'h0102, '0);
			begin
				starved = 1'b1;
				repeat (20) @(negedge clk);
				starved     = 1'b0;
				hold_credit = 1'b0;
			end
		join

		@(negedge clk);
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		#(NUM_OPS * 200 * 100);
		text_error("watchdog expired before the tests finished");
	end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
	parameter int SEED = 1
) (
	input  logic                clk,
	input  logic                n_rst,
	input  logic                hold_credit,
	input  cache_pkg::mem_req_t mem_req,
	output cache_pkg::mem_rsp_t mem_rsp,
	output logic                mem_credit
);
	import cache_pkg::*;

	logic [DATA_W-1:0] mem [2**ADDR_W];
	mem_req_t          pending [$];
	int                credit_due [$];
	integer            seed = SEED;
	int                cycle = 0;
	int                wait_left = -1;

	initial begin
		mem_rsp    = '0;
		mem_credit = 1'b0;
	end

	// writes land when the request is taken
	always @(posedge clk) begin
		if (n_rst && mem_req.valid) begin
			pending.push_back(mem_req);
			if (mem_req.write) begin
				mem[mem_req.addr] = mem_req.wdata;
			end
		end
	end

	always @(negedge clk) begin
		mem_rsp    = '0;
		mem_credit = 1'b0;
		cycle      = cycle + 1;
		if (!n_rst) begin
			pending.delete();
			credit_due.delete();
			wait_left = -1;
		end else begin
			if (pending.size() > 0 && wait_left < 0) begin
				wait_left = $unsigned($random(seed)) % 4;
			end else if (pending.size() > 0 && wait_left > 0) begin
				wait_left = wait_left - 1;
			end else if (pending.size() > 0) begin
				mem_rsp.valid = 1'b1;
				if (!pending[0].write) begin
					mem_rsp.rdata = mem[pending[0].addr];
				end
				void'(pending.pop_front());
				wait_left = -1;
				credit_due.push_back(cycle + $unsigned($random(seed)) % 6);
			end
			// at most one credit per cycle, late ones queue up
			if (!hold_credit && credit_due.size() > 0 && credit_due[0] <= cycle) begin
				void'(credit_due.pop_front());
				mem_credit = 1'b1;
			end
		end
	end

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top #(
	parameter int NUM_LINES   = 16,
	parameter int MEM_CREDITS = 2
) (
	input  logic                clk,
	input  logic                n_rst,
	input  logic                cpu_req,
	input  cache_pkg::cpu_req_t cpu_cmd,
	input  logic                cpu_flush,
	output cache_pkg::cpu_rsp_t cpu_rsp,
	output logic                cache_ready,
	output logic                flush_done,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp,
	input  logic                mem_credit
);
	import cache_pkg::*;

	mem_op_e           mem_op;
	logic              req_sent;
	logic              hit;
	logic              dirty;
	logic              fill_en;
	logic              cpu_wr_en;
	logic              flush_step;
	logic              clear_dirty;
	logic              flush_active;
	logic              cpu_done;
	logic [ADDR_W-1:0] victim_addr;
	logic [DATA_W-1:0] victim_data;
	logic [DATA_W-1:0] rdata;

	assign cpu_rsp = '{done: cpu_done, rdata: rdata};

	cache_controller u_ctrl (
		.clk           (clk),
		.n_rst         (n_rst),
		.cpu_req       (cpu_req),
		.cpu_rw        (cpu_cmd.rw),
		.cpu_flush     (cpu_flush),
		.hit           (hit),
		.dirty         (dirty),
		.flush_done    (flush_done),
		.mem_rsp_valid (mem_rsp.valid),
		.req_sent      (req_sent),
		.mem_op        (mem_op),
		.fill_en       (fill_en),
		.cpu_wr_en     (cpu_wr_en),
		.flush_step    (flush_step),
		.clear_dirty   (clear_dirty),
		.flush_active  (flush_active),
		.cache_ready   (cache_ready),
		.cpu_done      (cpu_done)
	);

	cache_datapath #(
		.NUM_LINES (NUM_LINES)
	) u_dp (
		.clk          (clk),
		.n_rst        (n_rst),
		.cpu_cmd      (cpu_cmd),
		.mem_rdata    (mem_rsp.rdata),
		.fill_en      (fill_en),
		.cpu_wr_en    (cpu_wr_en),
		.flush_active (flush_active),
		.flush_step   (flush_step),
		.clear_dirty  (clear_dirty),
		.hit          (hit),
		.dirty        (dirty),
		.victim_addr  (victim_addr),
		.victim_data  (victim_data),
		.rdata        (rdata),
		.flush_done   (flush_done)
	);

	mem_port #(
		.MEM_CREDITS (MEM_CREDITS)
	) u_mem (
		.clk         (clk),
		.n_rst       (n_rst),
		.mem_op      (mem_op),
		.cpu_addr    (cpu_cmd.addr),
		.victim_addr (victim_addr),
		.victim_data (victim_data),
		.mem_credit  (mem_credit),
		.req_sent    (req_sent),
		.mem_req     (mem_req)
	);

endmodule

//--- mem_port.sv
`timescale 1ns/1ps

module mem_port #(
	parameter int MEM_CREDITS = 2
) (
	input  logic                         clk,
	input  logic                         n_rst,
	input  cache_pkg::mem_op_e           mem_op,
	input  logic [cache_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [cache_pkg::ADDR_W-1:0] victim_addr,
	input  logic [cache_pkg::DATA_W-1:0] victim_data,
	input  logic                         mem_credit,
	output logic                         req_sent,
	output cache_pkg::mem_req_t          mem_req
);
	import cache_pkg::*;

	localparam int CNT_W = $clog2(MEM_CREDITS + 1);

	logic [CNT_W-1:0] credits;
	logic             issue;
	logic             is_write;

	// request leaves in the same cycle, if a credit is held
	assign issue    = (mem_op != MEM_NONE) && (credits != '0);
	assign is_write = (mem_op == MEM_WRITE);
	assign req_sent = issue;

	always_comb begin
		mem_req.valid = issue;
		mem_req.write = is_write;
		// reads fetch the CPU address, writes evict the victim
		mem_req.addr  = is_write ? victim_addr : cpu_addr;
		mem_req.wdata = is_write ? victim_data : '0;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			credits <= CNT_W'(MEM_CREDITS);
		end else begin
			case ({mem_credit, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath #(
	parameter int NUM_LINES = 16
) (
	input  logic                         clk,
	input  logic                         n_rst,
	input  cache_pkg::cpu_req_t          cpu_cmd,
	input  logic [cache_pkg::DATA_W-1:0] mem_rdata,
	input  logic                         fill_en,
	input  logic                         cpu_wr_en,
	input  logic                         flush_active,
	input  logic                         flush_step,
	input  logic                         clear_dirty,
	output logic                         hit,
	output logic                         dirty,
	output logic [cache_pkg::ADDR_W-1:0] victim_addr,
	output logic [cache_pkg::DATA_W-1:0] victim_data,
	output logic [cache_pkg::DATA_W-1:0] rdata,
	output logic                         flush_done
);
	import cache_pkg::*;

	localparam int IDX_W = $clog2(NUM_LINES);
	localparam int TAG_W = ADDR_W - IDX_W;

	logic [TAG_W-1:0]     tag_arr [NUM_LINES];
	logic [DATA_W-1:0]    data_arr [NUM_LINES];
	logic [NUM_LINES-1:0] valid_arr;
	logic [NUM_LINES-1:0] dirty_arr;
	logic [IDX_W-1:0]     cpu_idx;
	logic [TAG_W-1:0]     cpu_tag;
	logic [IDX_W-1:0]     flush_idx;
	logic [IDX_W-1:0]     line;

	assign cpu_idx = cpu_cmd.addr[IDX_W-1:0];
	assign cpu_tag = cpu_cmd.addr[ADDR_W-1:IDX_W];

	// flush walks the lines by its own counter
	assign line = flush_active ? flush_idx : cpu_idx;

	assign hit         = valid_arr[cpu_idx] && (tag_arr[cpu_idx] == cpu_tag);
	assign dirty       = valid_arr[line] && dirty_arr[line];
	assign victim_addr = {tag_arr[line], line};
	assign victim_data = data_arr[line];
	assign rdata       = data_arr[cpu_idx];
	assign flush_done  = flush_step && (flush_idx == IDX_W'(NUM_LINES - 1));

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_arr[cpu_idx]  <= cpu_tag;
			data_arr[cpu_idx] <= mem_rdata;
		end else if (cpu_wr_en) begin
			data_arr[cpu_idx] <= cpu_cmd.wdata;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			valid_arr <= '0;
			dirty_arr <= '0;
		end else if (fill_en) begin
			// fresh line from memory is clean
			valid_arr[cpu_idx] <= 1'b1;
			dirty_arr[cpu_idx] <= 1'b0;
		end else if (cpu_wr_en) begin
			dirty_arr[cpu_idx] <= 1'b1;
		end else if (clear_dirty) begin
			dirty_arr[line] <= 1'b0;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			flush_idx <= '0;
		end else if (flush_done) begin
			flush_idx <= '0;
		end else if (flush_step) begin
			flush_idx <= flush_idx + 1'b1;
		end
	end

endmodule

//--- cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               cpu_req,
	input  logic               cpu_rw,
	input  logic               cpu_flush,
	input  logic               hit,
	input  logic               dirty,
	input  logic               flush_done,
	input  logic               mem_rsp_valid,
	input  logic               req_sent,
	output cache_pkg::mem_op_e mem_op,
	output logic               fill_en,
	output logic               cpu_wr_en,
	output logic               flush_step,
	output logic               clear_dirty,
	output logic               flush_active,
	output logic               cache_ready,
	output logic               cpu_done
);
	import cache_pkg::*;

	cache_state_e state;
	cache_state_e next_state;
	logic         flushing;
	logic         cmd_sent;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// flush in progress, so a write-back knows where to return
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			flushing <= 1'b0;
		end else if (state == IDLE && cpu_flush && !cpu_req) begin
			flushing <= 1'b1;
		end else if (flush_done) begin
			flushing <= 1'b0;
		end
	end

	// memory command already issued in this state
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			cmd_sent <= 1'b0;
		end else if (next_state != state) begin
			cmd_sent <= 1'b0;
		end else if (req_sent) begin
			cmd_sent <= 1'b1;
		end
	end

	assign flush_active = flushing;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cpu_req) begin
					next_state = PROCESS_REQ;
				end else if (cpu_flush) begin
					next_state = FLUSH;
				end
			end
			PROCESS_REQ: begin
				if (hit) begin
					next_state = IDLE;
				end else if (dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = ALLOCATE;
				end
			end
			ALLOCATE: begin
				if (mem_rsp_valid) begin
					next_state = PROCESS_REQ;
				end
			end
			WRITEBACK: begin
				if (mem_rsp_valid) begin
					next_state = flushing ? FLUSH : ALLOCATE;
				end
			end
			FLUSH: begin
				if (flush_done) begin
					next_state = IDLE;
				end else if (dirty) begin
					next_state = WRITEBACK;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_comb begin
		mem_op      = MEM_NONE;
		fill_en     = 1'b0;
		cpu_wr_en   = 1'b0;
		flush_step  = 1'b0;
		clear_dirty = 1'b0;
		cache_ready = 1'b0;
		cpu_done    = 1'b0;
		case (state)
			IDLE: cache_ready = 1'b1;
			PROCESS_REQ: begin
				if (hit) begin
					cpu_done  = 1'b1;
					cpu_wr_en = cpu_rw;
				end
			end
			ALLOCATE: begin
				if (!cmd_sent) begin
					mem_op = MEM_READ;
				end
				fill_en = mem_rsp_valid;
			end
			WRITEBACK: begin
				if (!cmd_sent) begin
					mem_op = MEM_WRITE;
				end
				clear_dirty = mem_rsp_valid;
			end
			// clean lines are skipped, dirty ones go through write-back
			FLUSH: flush_step = !dirty;
			default: ;
		endcase
	end

endmodule

//--- cache_pkg.sv
package cache_pkg;

	// word address and data widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	typedef enum logic [2:0] {
		IDLE,
		PROCESS_REQ,
		ALLOCATE,
		WRITEBACK,
		FLUSH
	} cache_state_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

	// rw set means write
	typedef struct packed {
		logic              rw;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic              done;
		logic [DATA_W-1:0] rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic              valid;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

endpackage
